//--- src/icache_defines.svh
// Instruction cache geometry macros: address, set, line and word sizes
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// Fetch address width in bits
`define ICACHE_ADDR_W 32

// Direct-mapped storage, one line per set
`define ICACHE_SETS 8

// Words held by one line
`define ICACHE_WORDS 8

// Instruction word width
`define ICACHE_WORD_W 32

// Index widths, log2 of sets and words
`define ICACHE_SET_BITS 3
`define ICACHE_WORD_BITS 3

// Byte offset inside a word, ignored on fetch
`define ICACHE_BYTE_BITS 2

`endif

//--- src/icache_addr_pkg.sv
// Address package: fetch address field types and the instruction word type
`default_nettype none

`include "icache_defines.svh"

package icache_addr_pkg;

  // Full byte address as seen on the fetch ports
  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

  // Tag sits above set, word and byte fields
  typedef logic [`ICACHE_ADDR_W-`ICACHE_SET_BITS-`ICACHE_WORD_BITS-`ICACHE_BYTE_BITS-1:0]
    tag_t;

  // Set index
  typedef logic [`ICACHE_SET_BITS-1:0] set_idx_t;

  // Word within a line
  typedef logic [`ICACHE_WORD_BITS-1:0] word_idx_t;

  // One instruction
  typedef logic [`ICACHE_WORD_W-1:0] instr_t;

endpackage

`default_nettype wire

//--- src/icache_ctrl_pkg.sv
// Control package: line data type, line state and refill FSM state enums
`default_nettype none

`include "icache_defines.svh"

package icache_ctrl_pkg;

  // Whole cache line, word 0 in the low bits
  typedef logic [`ICACHE_WORDS*`ICACHE_WORD_W-1:0] line_t;

  // Per-set validity
  typedef enum logic {
    line_invalid = 1'b0,
    line_valid   = 1'b1
  } line_state_e;

  // Refill FSM, one state per handshake phase
  typedef enum logic [1:0] {
    refill_idle    = 2'd0,
    refill_req     = 2'd1,
    refill_release = 2'd2
  } refill_state_e;

endpackage

`default_nettype wire

//--- src/icache_line_array.sv
// Line array: tag, data and valid storage with two async read ports and one write port
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_line_array (
  input  logic                     cs,
  input  logic                     arst_n,
  // Read port 0
  input  icache_addr_pkg::set_idx_t rd_set_0,
  output icache_addr_pkg::tag_t     rd_tag_0,
  output icache_ctrl_pkg::line_t    rd_line_0,
  output logic                      rd_valid_0,
  // Read port 1
  input  icache_addr_pkg::set_idx_t rd_set_1,
  output icache_addr_pkg::tag_t     rd_tag_1,
  output icache_ctrl_pkg::line_t    rd_line_1,
  output logic                      rd_valid_1,
  // Line write from the refill controller
  input  logic                      wr_en,
  input  icache_addr_pkg::set_idx_t wr_set,
  input  icache_addr_pkg::tag_t     wr_tag,
  input  icache_ctrl_pkg::line_t    wr_line
);
  import icache_addr_pkg::*;
  import icache_ctrl_pkg::*;

  tag_t        tag_mem   [`ICACHE_SETS];
  line_t       data_mem  [`ICACHE_SETS];
  line_state_e state_q   [`ICACHE_SETS];

  // Payload storage, written whole-line
  always_ff @(posedge cs) begin
    if (wr_en) begin
      tag_mem[wr_set]  <= wr_tag;
      data_mem[wr_set] <= wr_line;
    end
  end

  // Valid bits come up invalid and only ever turn valid
  always_ff @(posedge cs or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `ICACHE_SETS; i++) begin
        state_q[i] <= line_invalid;
      end
    end else if (wr_en) begin
      state_q[wr_set] <= line_valid;
    end
  end

  // Asynchronous reads
  assign rd_tag_0   = tag_mem[rd_set_0];
  assign rd_line_0  = data_mem[rd_set_0];
  assign rd_valid_0 = (state_q[rd_set_0] == line_valid);

  assign rd_tag_1   = tag_mem[rd_set_1];
  assign rd_line_1  = data_mem[rd_set_1];
  assign rd_valid_1 = (state_q[rd_set_1] == line_valid);

  // Controller must stay quiet while the array is held in reset
  a_no_write_in_reset: assert property (
    @(posedge cs) !arst_n |-> !wr_en
  ) else $error("line array written during reset");

endmodule

`default_nettype wire

//--- src/icache_lookup.sv
// Fetch port lookup: address split, tag compare, hit, word select and miss report
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_lookup (
  // Fetch side
  input  logic                      read,
  input  icache_addr_pkg::addr_t    addr,
  output logic                      hit,
  output icache_addr_pkg::instr_t   instr,
  // Array side
  output icache_addr_pkg::set_idx_t set,
  input  icache_addr_pkg::tag_t     line_tag,
  input  icache_ctrl_pkg::line_t    line_data,
  input  logic                      line_valid,
  // Controller side
  output logic                      miss,
  output icache_addr_pkg::tag_t     miss_tag
);
  import icache_addr_pkg::*;

  localparam int WORD_LSB = `ICACHE_BYTE_BITS;
  localparam int SET_LSB  = WORD_LSB + `ICACHE_WORD_BITS;
  localparam int TAG_LSB  = SET_LSB + `ICACHE_SET_BITS;

  tag_t      addr_tag;
  word_idx_t word_sel;
  logic      match;

  // Byte offset bits are dropped
  assign addr_tag = addr[`ICACHE_ADDR_W-1:TAG_LSB];
  assign set      = addr[TAG_LSB-1:SET_LSB];
  assign word_sel = addr[SET_LSB-1:WORD_LSB];

  assign match = line_valid && (line_tag == addr_tag);

  assign hit      = read && match;
  assign instr    = hit ? line_data[word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W] : '0;
  assign miss     = read && !match;
  assign miss_tag = addr_tag;

endmodule

`default_nettype wire

//--- src/icache_refill_ctrl.sv
// Refill controller: miss arbitration, four-phase memory handshake and line write
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_refill_ctrl (
  input  logic                      cs,
  input  logic                      arst_n,
  // Misses from the two lookups
  input  logic                      miss_0,
  input  icache_addr_pkg::tag_t     miss_tag_0,
  input  icache_addr_pkg::set_idx_t miss_set_0,
  input  logic                      miss_1,
  input  icache_addr_pkg::tag_t     miss_tag_1,
  input  icache_addr_pkg::set_idx_t miss_set_1,
  // Backing memory
  output logic                      mem_req,
  output icache_addr_pkg::addr_t    mem_addr,
  input  logic                      mem_ack,
  input  icache_ctrl_pkg::line_t    mem_line,
  // Array write port
  output logic                      wr_en,
  output icache_addr_pkg::set_idx_t wr_set,
  output icache_addr_pkg::tag_t     wr_tag,
  output icache_ctrl_pkg::line_t    wr_line
);
  import icache_addr_pkg::*;
  import icache_ctrl_pkg::*;

  refill_state_e state_q;
  tag_t          tgt_tag_q;
  set_idx_t      tgt_set_q;

  // FSM
  always_ff @(posedge cs or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= refill_idle;
    end else begin
      case (state_q)
        refill_idle: begin
          // Misses are live from the array, so a line just filled no longer shows here
          if (miss_0 || miss_1) begin
            state_q <= refill_req;
          end
        end
        refill_req: begin
          if (mem_ack) begin
            state_q <= refill_release;
          end
        end
        refill_release: begin
          // Wait for ack low before a new request
          if (!mem_ack) begin
            state_q <= refill_idle;
          end
        end
        default: state_q <= refill_idle;
      endcase
    end
  end

  // Target line, port 0 first
  always_ff @(posedge cs) begin
    if (state_q == refill_idle) begin
      if (miss_0) begin
        tgt_tag_q <= miss_tag_0;
        tgt_set_q <= miss_set_0;
      end else if (miss_1) begin
        tgt_tag_q <= miss_tag_1;
        tgt_set_q <= miss_set_1;
      end
    end
  end

  assign mem_req  = (state_q == refill_req);
  // Line-aligned, word and byte bits zero
  assign mem_addr = {tgt_tag_q, tgt_set_q, {(`ICACHE_WORD_BITS + `ICACHE_BYTE_BITS){1'b0}}};

  // Line lands in the array on the ack edge
  assign wr_en   = mem_req && mem_ack;
  assign wr_set  = tgt_set_q;
  assign wr_tag  = tgt_tag_q;
  assign wr_line = mem_line;

  // Handshake ordering on the memory side
  a_req_held_until_ack: assert property (
    @(posedge cs) disable iff (!arst_n)
    mem_req && !mem_ack |=> mem_req
  ) else $error("mem_req dropped before mem_ack");

  a_addr_stable: assert property (
    @(posedge cs) disable iff (!arst_n)
    mem_req && !mem_ack |=> $stable(mem_addr)
  ) else $error("mem_addr changed during request");

endmodule

`default_nettype wire

//--- src/icache_top.sv
// Instruction cache top: line array, two fetch lookups and the refill controller
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_top (
  input  logic                    cs,
  input  logic                    arst_n,
  // Fetch port 0
  input  logic                    fetch_read_0,
  input  icache_addr_pkg::addr_t  fetch_addr_0,
  output logic                    fetch_hit_0,
  output icache_addr_pkg::instr_t fetch_instr_0,
  // Fetch port 1
  input  logic                    fetch_read_1,
  input  icache_addr_pkg::addr_t  fetch_addr_1,
  output logic                    fetch_hit_1,
  output icache_addr_pkg::instr_t fetch_instr_1,
  // Backing memory
  output logic                    mem_req,
  output icache_addr_pkg::addr_t  mem_addr,
  input  logic                    mem_ack,
  input  icache_ctrl_pkg::line_t  mem_line
);
  import icache_addr_pkg::*;
  import icache_ctrl_pkg::*;

  set_idx_t set_0, set_1;
  tag_t     tag_0, tag_1;
  line_t    line_0, line_1;
  logic     valid_0, valid_1;
  logic     miss_0, miss_1;
  tag_t     miss_tag_0, miss_tag_1;

  logic     wr_en;
  set_idx_t wr_set;
  tag_t     wr_tag;
  line_t    wr_line;

  icache_line_array array (
    .cs        (cs),
    .arst_n    (arst_n),
    .rd_set_0  (set_0),
    .rd_tag_0  (tag_0),
    .rd_line_0 (line_0),
    .rd_valid_0(valid_0),
    .rd_set_1  (set_1),
    .rd_tag_1  (tag_1),
    .rd_line_1 (line_1),
    .rd_valid_1(valid_1),
    .wr_en     (wr_en),
    .wr_set    (wr_set),
    .wr_tag    (wr_tag),
    .wr_line   (wr_line)
  );

  icache_lookup lookup_0 (
    .read      (fetch_read_0),
    .addr      (fetch_addr_0),
    .hit       (fetch_hit_0),
    .instr     (fetch_instr_0),
    .set       (set_0),
    .line_tag  (tag_0),
    .line_data (line_0),
    .line_valid(valid_0),
    .miss      (miss_0),
    .miss_tag  (miss_tag_0)
  );

  icache_lookup lookup_1 (
    .read      (fetch_read_1),
    .addr      (fetch_addr_1),
    .hit       (fetch_hit_1),
    .instr     (fetch_instr_1),
    .set       (set_1),
    .line_tag  (tag_1),
    .line_data (line_1),
    .line_valid(valid_1),
    .miss      (miss_1),
    .miss_tag  (miss_tag_1)
  );

  icache_refill_ctrl refill (
    .cs        (cs),
    .arst_n    (arst_n),
    .miss_0    (miss_0),
    .miss_tag_0(miss_tag_0),
    .miss_set_0(set_0),
    .miss_1    (miss_1),
    .miss_tag_1(miss_tag_1),
    .miss_set_1(set_1),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_ack   (mem_ack),
    .mem_line  (mem_line),
    .wr_en     (wr_en),
    .wr_set    (wr_set),
    .wr_tag    (wr_tag),
    .wr_line   (wr_line)
  );

endmodule

`default_nettype wire

//--- dv/icache_checker.sv
// Testbench checker: shadow tag table, reference words, refill count and handshake order
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_checker (
  input  logic                    cs,
  input  logic                    arst_n,
  input  logic                    fetch_read_0,
  input  icache_addr_pkg::addr_t  fetch_addr_0,
  input  logic                    fetch_hit_0,
  input  icache_addr_pkg::instr_t fetch_instr_0,
  input  logic                    fetch_read_1,
  input  icache_addr_pkg::addr_t  fetch_addr_1,
  input  logic                    fetch_hit_1,
  input  icache_addr_pkg::instr_t fetch_instr_1,
  input  logic                    mem_req,
  input  icache_addr_pkg::addr_t  mem_addr,
  input  logic                    mem_ack,
  input  logic                    test_done,
  input  logic [3:0]              test_id,
  output int                      tests_passed,
  output int                      tests_failed
);
  import icache_addr_pkg::*;

  localparam int SET_LSB    = `ICACHE_BYTE_BITS + `ICACHE_WORD_BITS;
  localparam int TAG_LSB    = SET_LSB + `ICACHE_SET_BITS;
  localparam int WAIT_LIMIT = 40;

  tag_t  shadow_tag   [`ICACHE_SETS];
  logic  shadow_valid [`ICACHE_SETS];
  logic  prev_read_0, prev_read_1, prev_req, prev_ack;
  logic  first_pending;
  addr_t first_line;
  int    wait_0, wait_1;
  int    refills, expected, errors, errors_seen;

  // Word at byte address A is A with the low two bits cleared, xor a constant
  function automatic instr_t expected_word(addr_t a);
    return {a[`ICACHE_ADDR_W-1:2], 2'b00} ^ 32'hA5C3_0F00;
  endfunction

  function automatic addr_t line_of(addr_t a);
    return {a[`ICACHE_ADDR_W-1:SET_LSB], {SET_LSB{1'b0}}};
  endfunction

  // True when the shadow table says the line is resident
  function automatic logic held(addr_t a);
    set_idx_t s;
    s = a[SET_LSB +: `ICACHE_SET_BITS];
    return shadow_valid[s] && (shadow_tag[s] == a[`ICACHE_ADDR_W-1:TAG_LSB]);
  endfunction

  task automatic check_port(input int port, input logic read, input addr_t a,
                            input logic hit, input instr_t instr);
    if (!read && hit) begin
      errors++;
      $display("FAIL %0t fetch_hit_%0d expected 0 actual 1", $time, port);
    end
    if (!read && instr != '0) begin
      errors++;
      $display("FAIL %0t fetch_instr_%0d expected 0 actual %h", $time, port, instr);
    end
    if (hit && !held(a)) begin
      errors++;
      $display("Port %0d hit at %h on a line that was never filled", port, a);
    end
    if (hit && instr != expected_word(a)) begin
      errors++;
      $display("FAIL %0t fetch_instr_%0d expected %h actual %h", $time, port,
               expected_word(a), instr);
    end
  endtask

  task automatic count_wait(input int port, input logic read, input logic hit,
                            inout int waited);
    if (read && !hit) begin
      waited++;
      if (waited == WAIT_LIMIT) begin
        errors++;
        $display("Read on port %0d unanswered for %0d cycles", port, WAIT_LIMIT);
      end
    end else begin
      waited = 0;
    end
  endtask

  task automatic report_test();
    if (refills != expected) begin
      errors++;
      $display("Test %0d saw %0d refills in total, %0d expected", test_id, refills, expected);
      expected = refills;
    end
    if (errors == errors_seen) begin
      tests_passed++;
      $display("Test %0d passed, %0d refills so far", test_id, refills);
    end else begin
      tests_failed++;
      $display("Test %0d failed with %0d errors", test_id, errors - errors_seen);
    end
    errors_seen = errors;
  endtask

  always @(negedge cs) begin
    logic     miss_0, miss_1;
    set_idx_t s;
    if (!arst_n) begin
      for (int i = 0; i < `ICACHE_SETS; i++) begin
        shadow_valid[i] = 1'b0;
      end
      {prev_read_0, prev_read_1, prev_req, prev_ack, first_pending} = '0;
      {wait_0, wait_1, refills, expected, errors, errors_seen} = '0;
      tests_passed = 0;
      tests_failed = 0;
    end else begin
      // Predicted misses for accesses that start now, port 0 served first
      miss_0 = fetch_read_0 && !prev_read_0 && !held(fetch_addr_0);
      miss_1 = fetch_read_1 && !prev_read_1 && !held(fetch_addr_1);
      if (miss_0) begin
        expected++;
      end
      if (miss_1 && !(miss_0 && line_of(fetch_addr_0) == line_of(fetch_addr_1))) begin
        expected++;
        if (miss_0) begin
          first_pending = 1'b1;
          first_line    = line_of(fetch_addr_0);
        end
      end

      check_port(0, fetch_read_0, fetch_addr_0, fetch_hit_0, fetch_instr_0);
      check_port(1, fetch_read_1, fetch_addr_1, fetch_hit_1, fetch_instr_1);
      count_wait(0, fetch_read_0, fetch_hit_0, wait_0);
      count_wait(1, fetch_read_1, fetch_hit_1, wait_1);

      if (prev_req && !mem_req && !prev_ack) begin
        errors++;
        $display("mem_req dropped before mem_ack was seen");
      end
      if (!prev_req && mem_req && mem_ack) begin
        errors++;
        $display("mem_req raised again while mem_ack was still high");
      end

      // Handshake completes in the cycle where req and ack are both high
      if (mem_req && mem_ack) begin
        refills++;
        if (mem_addr != line_of(mem_addr)) begin
          errors++;
          $display("Refill address %h is not line aligned", mem_addr);
        end
        if (held(mem_addr)) begin
          errors++;
          $display("Refill of line %h that is already resident", mem_addr);
        end
        if (first_pending && mem_addr != first_line) begin
          errors++;
          $display("FAIL %0t mem_addr expected %h actual %h", $time, first_line, mem_addr);
        end
        first_pending   = 1'b0;
        s               = mem_addr[SET_LSB +: `ICACHE_SET_BITS];
        shadow_tag[s]   = mem_addr[`ICACHE_ADDR_W-1:TAG_LSB];
        shadow_valid[s] = 1'b1;
      end

      if (test_done) begin
        report_test();
      end
      prev_read_0 = fetch_read_0;
      prev_read_1 = fetch_read_1;
      prev_req    = mem_req;
      prev_ack    = mem_ack;
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_icache.sv
// Testbench top: clock, reset, fetch stimulus, backing memory model and run timeout
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module tb_icache;
  import icache_addr_pkg::*;
  import icache_ctrl_pkg::*;

  localparam int NUM_TESTS    = 6;
  localparam int MAX_ACCESSES = 200;
  localparam int CYCLE_LIMIT  = NUM_TESTS * MAX_ACCESSES * 40;

  logic       cs = 1'b0;
  logic       arst_n = 1'b0;
  logic       fetch_read_0 = 1'b0;
  addr_t      fetch_addr_0 = '0;
  logic       fetch_hit_0;
  instr_t     fetch_instr_0;
  logic       fetch_read_1 = 1'b0;
  addr_t      fetch_addr_1 = '0;
  logic       fetch_hit_1;
  instr_t     fetch_instr_1;
  logic       mem_req;
  addr_t      mem_addr;
  logic       mem_ack = 1'b0;
  line_t      mem_line = '0;
  logic       test_done = 1'b0;
  logic [3:0] test_id = '0;
  int         tests_passed, tests_failed;
  int         mem_wait = 0;
  int         cycles = 0;
  integer     seed = 32'h13c5;
  integer     mem_seed = 32'h13c5;

  icache_top dut0 (
    .cs           (cs),
    .arst_n       (arst_n),
    .fetch_read_0 (fetch_read_0),
    .fetch_addr_0 (fetch_addr_0),
    .fetch_hit_0  (fetch_hit_0),
    .fetch_instr_0(fetch_instr_0),
    .fetch_read_1 (fetch_read_1),
    .fetch_addr_1 (fetch_addr_1),
    .fetch_hit_1  (fetch_hit_1),
    .fetch_instr_1(fetch_instr_1),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .mem_ack      (mem_ack),
    .mem_line     (mem_line)
  );

  icache_checker chk0 (
    .cs(cs), .arst_n(arst_n),
    .fetch_read_0(fetch_read_0), .fetch_addr_0(fetch_addr_0),
    .fetch_hit_0(fetch_hit_0), .fetch_instr_0(fetch_instr_0),
    .fetch_read_1(fetch_read_1), .fetch_addr_1(fetch_addr_1),
    .fetch_hit_1(fetch_hit_1), .fetch_instr_1(fetch_instr_1),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack),
    .test_done(test_done), .test_id(test_id),
    .tests_passed(tests_passed), .tests_failed(tests_failed)
  );

  always #10 cs = ~cs;

  // Backing memory content for one line
  function automatic line_t fill_line(addr_t base);
    line_t l;
    addr_t a;
    for (int w = 0; w < `ICACHE_WORDS; w++) begin
      a = base + addr_t'(w * 4);
      l[w*`ICACHE_WORD_W +: `ICACHE_WORD_W] = {a[`ICACHE_ADDR_W-1:2], 2'b00} ^ 32'hA5C3_0F00;
    end
    return l;
  endfunction

  // Four-phase responder, ack after 2 to 5 cycles
  always @(posedge cs or negedge arst_n) begin
    if (!arst_n) begin
      mem_ack  <= 1'b0;
      mem_wait <= 0;
    end else if (mem_ack) begin
      if (!mem_req) begin
        mem_ack <= 1'b0;
      end
    end else if (mem_req) begin
      if (mem_wait == 0) begin
        mem_wait <= 2 + ($random(mem_seed) & 3);
      end else if (mem_wait == 1) begin
        mem_ack  <= 1'b1;
        mem_line <= fill_line(mem_addr);
        mem_wait <= 0;
      end else begin
        mem_wait <= mem_wait - 1;
      end
    end
  end

  always @(posedge cs) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped by timeout after %0d cycles", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // Both ports start together, each drops read once its hit is seen
  task automatic fetch_pair(input logic use_0, input addr_t a0,
                            input logic use_1, input addr_t a1);
    logic done_0, done_1, got_0, got_1;
    done_0 = !use_0;
    done_1 = !use_1;
    @(posedge cs);
    fetch_read_0 <= use_0;
    fetch_addr_0 <= a0;
    fetch_read_1 <= use_1;
    fetch_addr_1 <= a1;
    while (!(done_0 && done_1)) begin
      @(negedge cs);
      got_0 = !done_0 && fetch_hit_0;
      got_1 = !done_1 && fetch_hit_1;
      @(posedge cs);
      if (got_0) begin
        fetch_read_0 <= 1'b0;
        done_0 = 1'b1;
      end
      if (got_1) begin
        fetch_read_1 <= 1'b0;
        done_1 = 1'b1;
      end
    end
  endtask

  task automatic end_test(input int id);
    @(posedge cs);
    test_id   <= 4'(id);
    test_done <= 1'b1;
    @(posedge cs);
    test_done <= 1'b0;
  endtask

  function automatic addr_t rand_addr();
    return 32'h0001_0000 | (addr_t'($random(seed)) & 32'h0000_0ffc);
  endfunction

  initial begin
    repeat (3) @(posedge cs);
    arst_n <= 1'b1;
    @(posedge cs);

    // Cold miss, then the whole line from the same fill
    fetch_pair(1'b1, 32'h0000_1040, 1'b0, '0);
    end_test(1);
    for (int w = 0; w < `ICACHE_WORDS; w++) begin
      fetch_pair(1'b1, 32'h0000_1040 + addr_t'(w * 4), 1'b0, '0);
    end
    end_test(2);
    // Different sets on both ports, then one shared line
    fetch_pair(1'b1, 32'h0000_2080, 1'b1, 32'h0000_30c0);
    end_test(3);
    fetch_pair(1'b1, 32'h0000_5104, 1'b1, 32'h0000_5118);
    end_test(4);
    // Same set as 0x1040 with another tag, then back
    fetch_pair(1'b1, 32'h0000_9040, 1'b0, '0);
    fetch_pair(1'b1, 32'h0000_1044, 1'b0, '0);
    end_test(5);
    for (int i = 0; i < MAX_ACCESSES; i++) begin
      fetch_pair(1'b1, rand_addr(), 1'b1, rand_addr());
    end
    end_test(6);

    repeat (2) @(posedge cs);
    $display("Tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && tests_passed == NUM_TESTS) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+src
src/icache_addr_pkg.sv
src/icache_ctrl_pkg.sv
src/icache_line_array.sv
src/icache_lookup.sv
src/icache_refill_ctrl.sv
src/icache_top.sv
dv/icache_checker.sv
dv/tb_icache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the instruction cache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_icache \
  -Mdir obj_dir -o sim_icache > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_icache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TB PASSED" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
